//--- filelist.f
+incdir+.
mipsPkg.sv
fetchUnit.sv
decodeCtrl.sv
regFile.sv
hazardUnit.sv
aluUnit.sv
memBridge.sv
mipsCore.sv
tbSram.sv
tbMips.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - fetchUnit.sv
      - decodeCtrl.sv
      - regFile.sv
      - hazardUnit.sv
      - aluUnit.sv
      - memBridge.sv
      - mipsCore.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbSram.sv
      - tbMips.sv

//--- tbMips.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module tbMips;
	import mipsPkg::*;

	logic clk;
	logic reset;
	logic instEn;
	wordT instAddr;
	wordT instRdata;
	sramReqT dataReq;
	wordT dataRdata;
	debugWbT debugWb;

	debugWbT expQ [$];
	wordT modelRegs [32];
	logic pcSeen [256];
	wordT sbAddr;
	logic [3:0] sbStrobe;
	int valueErrors;
	int otherErrors;
	int sbCount;

	mipsCore UUT (
		.clk(clk), .reset(reset), .instEn(instEn), .instAddr(instAddr),
		.instRdata(instRdata), .dataReq(dataReq), .dataRdata(dataRdata), .debugWb(debugWb)
	);

	tbSram memory (
		.clk(clk), .instEn(instEn), .instAddr(instAddr), .instRdata(instRdata),
		.dataReq(dataReq), .dataRdata(dataRdata)
	);

	always #4 clk = ~clk;

	task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
		valueErrors++;
		$display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		otherErrors++;
		$display("Failure: %s", what);
	endtask

	task automatic modelWrite(input wordT pc, input regNumT dest, input wordT value);
		if (dest != '0) begin
			modelRegs[dest] = value;
			expQ.push_back('{pc: pc, wen: 4'hf, wnum: dest, wdata: value});
		end
	endtask

	// ********************************************************************
	// In-order model of the program with one delay slot per branch or jump
	// ********************************************************************
	task automatic buildModel();
		wordT pc;
		wordT npc;
		wordT nextNpc;
		wordT instr;
		wordT a;
		wordT b;
		wordT sImm;
		wordT addr;
		wordT mem [256];
		logic done;
		for (int i = 0; i < 256; i++) begin
			mem[i] = memory.dataMem[i];
		end
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		pc = `MIPS_RESET_PC;
		npc = pc + 4;
		done = 1'b0;
		for (int step = 0; step < 200 && !done; step++) begin
			instr = memory.instMem[pc[9:2]];
			a = modelRegs[instr[25:21]];
			b = modelRegs[instr[20:16]];
			sImm = {{16{instr[15]}}, instr[15:0]};
			addr = a + sImm;
			nextNpc = npc + 4;
			case (instr[31:26])
			OP_SPECIAL: begin
				case (instr[5:0])
				6'h21: modelWrite(pc, instr[15:11], a + b);
				6'h23: modelWrite(pc, instr[15:11], a - b);
				6'h24: modelWrite(pc, instr[15:11], a & b);
				6'h25: modelWrite(pc, instr[15:11], a | b);
				6'h2a: modelWrite(pc, instr[15:11], {31'd0, $signed(a) < $signed(b)});
				default: ;
				endcase
			end
			OP_ADDIU: modelWrite(pc, instr[20:16], addr);
			OP_ORI: modelWrite(pc, instr[20:16], a | {16'h0000, instr[15:0]});
			OP_LUI: modelWrite(pc, instr[20:16], {instr[15:0], 16'h0000});
			OP_LW: modelWrite(pc, instr[20:16], mem[addr[9:2]]);
			OP_LBU: modelWrite(pc, instr[20:16], {24'd0, mem[addr[9:2]][8*addr[1:0] +: 8]});
			OP_SW: mem[addr[9:2]] = b;
			OP_SB: begin
				mem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
				// Only the lane named by the low address bits is written.
				sbAddr = addr;
				sbStrobe = 4'h0;
				sbStrobe[addr[1:0]] = 1'b1;
			end
			OP_BEQ: begin
				if (a == b) begin
					nextNpc = pc + 4 + {sImm[29:0], 2'b00};
				end
			end
			OP_BNE: begin
				if (a != b) begin
					nextNpc = pc + 4 + {sImm[29:0], 2'b00};
				end
			end
			OP_J: begin
				nextNpc = {npc[31:28], instr[25:0], 2'b00};
				// A jump onto itself marks the end of the program.
				done = nextNpc == pc;
			end
			default: ;
			endcase
			pc = npc;
			npc = nextNpc;
		end
	endtask

	// Trace events are compared once per cycle while memWb is settled.
	always @(negedge clk) begin
		debugWbT expected;
		if (!reset && debugWb.wen != 4'h0) begin
			assert (!pcSeen[debugWb.pc[9:2]])
				else reportFailure($sformatf("trace repeats pc 0x%08h", debugWb.pc));
			pcSeen[debugWb.pc[9:2]] = 1'b1;
			assert (expQ.size() != 0)
				else reportFailure("register write after the model ran out of writes");
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				assert (debugWb.pc == expected.pc)
					else reportMismatch("trace pc", expected.pc, debugWb.pc);
				assert (debugWb.wnum == expected.wnum)
					else reportMismatch("trace register", expected.wnum, debugWb.wnum);
				assert (debugWb.wdata == expected.wdata)
					else reportMismatch("trace data", expected.wdata, debugWb.wdata);
			end
		end
		// Any partial strobe must belong to the program's single SB.
		if (!reset && dataReq.en && dataReq.wen != 4'h0 && dataReq.wen != 4'hf) begin
			sbCount++;
			assert (dataReq.addr == sbAddr)
				else reportMismatch("byte store address", sbAddr, dataReq.addr);
			assert (dataReq.wen == sbStrobe)
				else reportMismatch("byte strobe", sbStrobe, dataReq.wen);
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		debugWb.wen inside {4'h0, 4'hf})
		else reportMismatch("trace strobe", 32'hf, $sampled(debugWb.wen));

	assert property (@(posedge clk) disable iff (reset)
		debugWb.wen != 4'h0 |-> debugWb.wnum != '0)
		else reportFailure("trace shows a write to register zero");

	initial begin
		int cycles;
		logic timedOut;
		clk = 1'b0;
		reset = 1'b1;
		valueErrors = 0;
		otherErrors = 0;
		sbCount = 0;
		sbAddr = '0;
		sbStrobe = 4'h0;
		for (int i = 0; i < 256; i++) begin
			pcSeen[i] = 1'b0;
		end
		@(negedge clk);
		buildModel();
		assert (instEn) else reportFailure("instEn is low during reset");
		assert (instAddr == `MIPS_RESET_PC)
			else reportMismatch("reset pc", `MIPS_RESET_PC, instAddr);
		assert (dataReq.wen == 4'h0) else reportMismatch("reset data strobe", 0, dataReq.wen);
		assert (debugWb.wen == 4'h0) else reportMismatch("reset trace strobe", 0, debugWb.wen);
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		while (expQ.size() != 0 && cycles < 3000) begin
			@(posedge clk);
			cycles++;
		end
		timedOut = expQ.size() != 0;
		if (timedOut) begin
			reportFailure($sformatf("timeout with %0d register writes missing", expQ.size()));
		end
		// Let the final loop spin to catch stray writes.
		cycles = 0;
		while (cycles < 40) begin
			@(posedge clk);
			cycles++;
		end
		assert (sbCount > 0) else reportFailure("no byte store reached the data SRAM");

		$display("Checks finished with %0d value errors and %0d other errors",
			valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- tbSram.sv
`timescale 1ns/10ps

module tbSram (
	input logic clk,
	input logic instEn,
	input mipsPkg::wordT instAddr,
	output mipsPkg::wordT instRdata,
	input mipsPkg::sramReqT dataReq,
	output mipsPkg::wordT dataRdata
);
	import mipsPkg::*;

	localparam int DEPTH = 256;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	wordT instMem [DEPTH];
	wordT dataMem [DEPTH];
	logic [15:0] lfsrState;
	int slot;

	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
	endfunction

	// One LFSR step per bit handed out.
	function logic [15:0] takeBits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[14:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	// Every bit of the byte address shapes the initial data word.
	function automatic wordT fillWord(input wordT addr);
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	function automatic wordT rType(input regNumT rs, input regNumT rt, input regNumT rd,
			input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic wordT iType(input opcodeT op, input regNumT rs, input regNumT rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input wordT word);
		instMem[slot] = word;
		slot++;
	endtask

	initial begin
		logic [15:0] sbOffset;
		instRdata = '0;
		dataRdata = '0;
		lfsrState = 16'd9976;
		for (int i = 0; i < DEPTH; i++) begin
			instMem[i] = '0;
			dataMem[i] = fillWord(i * 4);
		end
		slot = 0;
		// ALU chain, each result feeding the next instruction.
		emit(iType(OP_ADDIU, 5'd0, 5'd1, takeBits(16)));
		emit(iType(OP_ORI, 5'd0, 5'd2, takeBits(16)));
		emit(rType(5'd1, 5'd2, 5'd3, FN_ADDU));
		emit(rType(5'd3, 5'd1, 5'd4, FN_SUBU));
		emit(rType(5'd4, 5'd3, 5'd5, FN_AND));
		emit(rType(5'd5, 5'd4, 5'd6, FN_OR));
		emit(rType(5'd4, 5'd6, 5'd7, FN_SLT));
		emit(iType(OP_LUI, 5'd0, 5'd8, takeBits(16)));
		emit(iType(OP_ORI, 5'd8, 5'd8, takeBits(16)));
		emit(iType(OP_ADDIU, 5'd0, 5'd9, 16'h0100));
		// Loads with a dependent instruction right behind.
		emit(iType(OP_SW, 5'd9, 5'd8, 16'h0000));
		emit(iType(OP_LW, 5'd9, 5'd10, 16'h0000));
		emit(rType(5'd10, 5'd3, 5'd11, FN_ADDU));
		emit(iType(OP_LW, 5'd9, 5'd12, 16'h0004));
		emit(rType(5'd12, 5'd12, 5'd13, FN_ADDU));
		sbOffset = 16'd8 + takeBits(2);
		emit(iType(OP_SB, 5'd9, 5'd1, sbOffset));
		emit(iType(OP_LBU, 5'd9, 5'd14, sbOffset));
		emit(rType(5'd14, 5'd2, 5'd15, FN_ADDU));
		// Taken BEQ at 72 lands on 84, so 80 never runs.
		emit(iType(OP_BEQ, 5'd3, 5'd3, 16'd2));
		emit(iType(OP_ADDIU, 5'd0, 5'd16, takeBits(16)));
		emit(iType(OP_ADDIU, 5'd0, 5'd17, 16'd1));
		emit(iType(OP_BNE, 5'd16, 5'd16, 16'd4));
		emit(iType(OP_ADDIU, 5'd16, 5'd18, 16'd5));
		emit(iType(OP_LW, 5'd9, 5'd19, 16'h0000));
		emit(iType(OP_BEQ, 5'd19, 5'd8, 16'd2));
		emit(rType(5'd19, 5'd1, 5'd20, FN_ADDU));
		emit(iType(OP_ADDIU, 5'd0, 5'd21, 16'd7));
		// Final J to itself with a write to register zero in its delay slot.
		emit({OP_J, 26'd27});
		emit(rType(5'd1, 5'd2, 5'd0, FN_ADDU));
	end

	always @(posedge clk) begin
		if (instEn) begin
			instRdata <= instMem[instAddr[9:2]];
		end
		if (dataReq.en) begin
			dataRdata <= dataMem[dataReq.addr[9:2]];
			for (int b = 0; b < 4; b++) begin
				if (dataReq.wen[b]) begin
					dataMem[dataReq.addr[9:2]][8*b +: 8] <= dataReq.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
	input logic clk,
	input logic reset,
	output logic instEn,
	output mipsPkg::wordT instAddr,
	input mipsPkg::wordT instRdata,
	output mipsPkg::sramReqT dataReq,
	input mipsPkg::wordT dataRdata,
	output mipsPkg::debugWbT debugWb
);
	import mipsPkg::*;

	wordT pcId;
	wordT instrId;
	logic validId;
	ctrlT ctrlId;
	wordT imm32Id;
	logic isBranchId;
	logic redirectId;
	wordT targetId;
	logic takeRedirect;
	wordT rfRs;
	wordT rfRt;
	wordT rsId;
	wordT rtId;

	fwdSelT fwdExA;
	fwdSelT fwdExB;
	fwdSelT fwdIdA;
	fwdSelT fwdIdB;
	logic stall;

	idExT idEx;
	exMemT exMem;
	memWbT memWb;
	wordT aluResult;
	wordT storeData;
	wordT loadValue;
	wordT memResult;
	logic memIsLoad;

	// ********************************************************************
	// Fetch and decode
	// ********************************************************************

	// A stalled branch has stale operands, so it may not steer fetch yet.
	assign takeRedirect = validId && redirectId && !stall;

	fetchUnit uFetch (
		.clk(clk), .reset(reset), .stall(stall), .redirect(takeRedirect),
		.target(targetId), .instRdata(instRdata), .instEn(instEn), .instAddr(instAddr),
		.pcId(pcId), .instrId(instrId), .validId(validId)
	);

	decodeCtrl uDecode (
		.instr(instrId), .pc(pcId), .rsValue(rsId), .rtValue(rtId), .ctrl(ctrlId),
		.imm32(imm32Id), .isBranch(isBranchId), .redirect(redirectId), .target(targetId)
	);

	regFile uRegs (
		.clk(clk), .reset(reset), .rsAddr(instrId[25:21]), .rtAddr(instrId[20:16]),
		.rsValue(rfRs), .rtValue(rfRt), .wbEn(memWb.valid && memWb.regWrite),
		.wbAddr(memWb.dest), .wbData(memWb.result)
	);

	hazardUnit uHazard (
		.clk(clk), .reset(reset), .rs(instrId[25:21]), .rt(instrId[20:16]),
		.isBranch(validId && isBranchId), .idEx(idEx), .exMem(exMem), .memWb(memWb),
		.fwdExA(fwdExA), .fwdExB(fwdExB), .fwdIdA(fwdIdA), .fwdIdB(fwdIdB), .stall(stall)
	);

	assign rsId = fwdValue(fwdIdA, rfRs, exMem.aluResult, memWb.result);
	assign rtId = fwdValue(fwdIdB, rfRt, exMem.aluResult, memWb.result);

	always_ff @(posedge clk) begin
		if (reset || stall || !validId) begin
			idEx <= '0;
		end else begin
			idEx <= '{
				valid: 1'b1,
				pc: pcId,
				ctrl: ctrlId,
				rs: instrId[25:21],
				rt: instrId[20:16],
				rsValue: rsId,
				rtValue: rtId,
				imm32: imm32Id
			};
		end
	end

	// ********************************************************************
	// Execute and memory
	// ********************************************************************

	aluUnit uAlu (
		.idEx(idEx), .memValue(exMem.aluResult), .wbValue(memWb.result),
		.fwdA(fwdExA), .fwdB(fwdExB), .result(aluResult), .storeData(storeData)
	);

	memBridge uMem (
		.clk(clk), .reset(reset), .exCtrl(idEx.ctrl), .addr(aluResult),
		.storeData(storeData), .memCtrl(exMem.ctrl), .byteOffset(exMem.byteOffset),
		.dataRdata(dataRdata), .dataReq(dataReq), .loadValue(loadValue)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem <= '{
				valid: idEx.valid,
				pc: idEx.pc,
				ctrl: idEx.ctrl,
				aluResult: aluResult,
				byteOffset: aluResult[1:0]
			};
		end
	end

	assign memIsLoad = exMem.ctrl.memOp inside {MEM_LW, MEM_LBU};
	assign memResult = memIsLoad ? loadValue : exMem.aluResult;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb <= '{
				valid: exMem.valid,
				pc: exMem.pc,
				regWrite: exMem.ctrl.regWrite,
				dest: exMem.ctrl.dest,
				result: memResult
			};
		end
	end

	// Trace of every register write leaving the pipe.
	assign debugWb.pc = memWb.pc;
	assign debugWb.wen = {4{memWb.valid && memWb.regWrite && memWb.dest != '0}};
	assign debugWb.wnum = memWb.dest;
	assign debugWb.wdata = memWb.result;

endmodule

//--- memBridge.sv
`timescale 1ns/10ps

module memBridge (
	input logic clk,
	input logic reset,
	input mipsPkg::ctrlT exCtrl,
	input mipsPkg::wordT addr,
	input mipsPkg::wordT storeData,
	input mipsPkg::ctrlT memCtrl,
	input logic [1:0] byteOffset,
	input mipsPkg::wordT dataRdata,
	output mipsPkg::sramReqT dataReq,
	output mipsPkg::wordT loadValue
);
	import mipsPkg::*;

	logic [7:0] loadByte;

	// The request leaves at the end of execute, data returns during memory.
	always_comb begin
		dataReq.en = exCtrl.memOp != MEM_NONE;
		dataReq.addr = addr;
		dataReq.wdata = storeData;
		case (exCtrl.memOp)
		MEM_SW: dataReq.wen = 4'b1111;
		MEM_SB: begin
			dataReq.wen = 4'b0001 << addr[1:0];
			dataReq.wdata = {4{storeData[7:0]}};
		end
		default: dataReq.wen = 4'b0000;
		endcase
	end

	assign loadByte = dataRdata[{byteOffset, 3'b000} +: 8];
	assign loadValue = (memCtrl.memOp == MEM_LBU) ? {24'h000000, loadByte} : dataRdata;

	assert property (@(posedge clk) disable iff (reset)
		dataReq.en && (exCtrl.memOp inside {MEM_LW, MEM_SW}) |-> addr[1:0] == 2'b00)
		else $error("word access to unaligned address 0x%08h", addr);

endmodule

//--- aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
	input mipsPkg::idExT idEx,
	input mipsPkg::wordT memValue,
	input mipsPkg::wordT wbValue,
	input mipsPkg::fwdSelT fwdA,
	input mipsPkg::fwdSelT fwdB,
	output mipsPkg::wordT result,
	output mipsPkg::wordT storeData
);
	import mipsPkg::*;

	wordT opA;
	wordT opB;

	assign opA = fwdValue(fwdA, idEx.rsValue, memValue, wbValue);
	assign storeData = fwdValue(fwdB, idEx.rtValue, memValue, wbValue);
	assign opB = idEx.ctrl.useImm ? idEx.imm32 : storeData;

	always_comb begin
		case (idEx.ctrl.aluOp)
		ALU_ADD: result = opA + opB;
		ALU_SUB: result = opA - opB;
		ALU_AND: result = opA & opB;
		ALU_OR: result = opA | opB;
		ALU_SLT: result = {31'd0, $signed(opA) < $signed(opB)};
		ALU_LUI: result = {opB[15:0], 16'h0000};
		default: result = opB;
		endcase
	end

endmodule

//--- hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input logic clk,
	input logic reset,
	input mipsPkg::regNumT rs,
	input mipsPkg::regNumT rt,
	input logic isBranch,
	input mipsPkg::idExT idEx,
	input mipsPkg::exMemT exMem,
	input mipsPkg::memWbT memWb,
	output mipsPkg::fwdSelT fwdExA,
	output mipsPkg::fwdSelT fwdExB,
	output mipsPkg::fwdSelT fwdIdA,
	output mipsPkg::fwdSelT fwdIdB,
	output logic stall
);
	import mipsPkg::*;

	logic exIsLoad;
	logic memIsLoad;
	logic exHitRs;
	logic exHitRt;
	logic memHitRs;
	logic memHitRt;
	logic loadUse;
	logic branchDep;

	function automatic logic hits(input logic valid, input logic regWrite,
			input regNumT dest, input regNumT src);
		return valid && regWrite && dest != '0 && dest == src;
	endfunction

	// The memory stage is younger than write-back, so it wins.
	function automatic fwdSelT pick(input regNumT src, input logic skipLoad);
		if (hits(exMem.valid, exMem.ctrl.regWrite, exMem.ctrl.dest, src) &&
				!(skipLoad && memIsLoad)) begin
			return FWD_FROM_MEM;
		end else if (hits(memWb.valid, memWb.regWrite, memWb.dest, src)) begin
			return FWD_FROM_WB;
		end
		return FWD_REGFILE;
	endfunction

	assign exIsLoad = idEx.ctrl.memOp inside {MEM_LW, MEM_LBU};
	assign memIsLoad = exMem.ctrl.memOp inside {MEM_LW, MEM_LBU};
	assign exHitRs = hits(idEx.valid, idEx.ctrl.regWrite, idEx.ctrl.dest, rs);
	assign exHitRt = hits(idEx.valid, idEx.ctrl.regWrite, idEx.ctrl.dest, rt);
	assign memHitRs = hits(exMem.valid, exMem.ctrl.regWrite, exMem.ctrl.dest, rs);
	assign memHitRt = hits(exMem.valid, exMem.ctrl.regWrite, exMem.ctrl.dest, rt);

	assign loadUse = exIsLoad && (exHitRs || exHitRt);
	assign branchDep = isBranch && (exHitRs || exHitRt || (memIsLoad && (memHitRs || memHitRt)));
	assign stall = loadUse || branchDep;

	always_comb begin
		fwdExA = pick(idEx.rs, 1'b0);
		fwdExB = pick(idEx.rt, 1'b0);
		fwdIdA = pick(rs, 1'b1);
		fwdIdB = pick(rt, 1'b1);
	end

	// A branch right after a load waits for the load to reach write-back.
	assert property (@(posedge clk) disable iff (reset)
		stall [*2] |=> !stall)
		else $error("pipeline stalled for more than two cycles");

endmodule

//--- regFile.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module regFile (
	input logic clk,
	input logic reset,
	input mipsPkg::regNumT rsAddr,
	input mipsPkg::regNumT rtAddr,
	output mipsPkg::wordT rsValue,
	output mipsPkg::wordT rtValue,
	input logic wbEn,
	input mipsPkg::regNumT wbAddr,
	input mipsPkg::wordT wbData
);
	import mipsPkg::*;

	wordT regs [`MIPS_NREGS];

	// A write in this cycle is returned at once, so decode sees write-back data.
	function automatic wordT readPort(input regNumT addr);
		if (addr == '0) begin
			return '0;
		end else if (wbEn && wbAddr == addr) begin
			return wbData;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!reset && wbEn && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	always_comb begin
		rsValue = readPort(rsAddr);
		rtValue = readPort(rtAddr);
	end

endmodule

//--- decodeCtrl.sv
`timescale 1ns/10ps

module decodeCtrl (
	input mipsPkg::wordT instr,
	input mipsPkg::wordT pc,
	input mipsPkg::wordT rsValue,
	input mipsPkg::wordT rtValue,
	output mipsPkg::ctrlT ctrl,
	output mipsPkg::wordT imm32,
	output logic isBranch,
	output logic redirect,
	output mipsPkg::wordT target
);
	import mipsPkg::*;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	opcodeT op;
	logic [5:0] funct;
	wordT signImm;
	wordT zeroImm;
	wordT seqPc;
	logic operandsEqual;

	assign op = opcodeT'(instr[31:26]);
	assign funct = instr[5:0];
	assign signImm = {{16{instr[15]}}, instr[15:0]};
	assign zeroImm = {16'h0000, instr[15:0]};
	assign seqPc = pc + 32'd4;
	assign operandsEqual = rsValue == rtValue;

	always_comb begin
		ctrl = '{aluOp: ALU_PASSB, useImm: 1'b0, memOp: MEM_NONE, regWrite: 1'b0, dest: '0};
		imm32 = signImm;
		isBranch = 1'b0;
		redirect = 1'b0;
		target = seqPc + {signImm[29:0], 2'b00};
		case (op)
		OP_SPECIAL: begin
			ctrl.dest = instr[15:11];
			ctrl.regWrite = 1'b1;
			case (funct)
			FN_ADDU: ctrl.aluOp = ALU_ADD;
			FN_SUBU: ctrl.aluOp = ALU_SUB;
			FN_AND: ctrl.aluOp = ALU_AND;
			FN_OR: ctrl.aluOp = ALU_OR;
			FN_SLT: ctrl.aluOp = ALU_SLT;
			default: ctrl.regWrite = 1'b0;
			endcase
		end
		OP_ADDIU, OP_LW, OP_LBU: begin
			ctrl.aluOp = ALU_ADD;
			ctrl.useImm = 1'b1;
			ctrl.regWrite = 1'b1;
			ctrl.dest = instr[20:16];
			if (op == OP_LW) begin
				ctrl.memOp = MEM_LW;
			end else if (op == OP_LBU) begin
				ctrl.memOp = MEM_LBU;
			end
		end
		OP_SW, OP_SB: begin
			ctrl.aluOp = ALU_ADD;
			ctrl.useImm = 1'b1;
			ctrl.memOp = (op == OP_SW) ? MEM_SW : MEM_SB;
		end
		OP_ORI, OP_LUI: begin
			// Both take the unsigned immediate.
			ctrl.aluOp = (op == OP_ORI) ? ALU_OR : ALU_LUI;
			ctrl.useImm = 1'b1;
			ctrl.regWrite = 1'b1;
			ctrl.dest = instr[20:16];
			imm32 = zeroImm;
		end
		OP_BEQ, OP_BNE: begin
			isBranch = 1'b1;
			redirect = (op == OP_BEQ) ? operandsEqual : !operandsEqual;
		end
		OP_J: begin
			redirect = 1'b1;
			target = {seqPc[31:28], instr[25:0], 2'b00};
		end
		default: begin
			ctrl.regWrite = 1'b0;
		end
		endcase
	end

endmodule

//--- fetchUnit.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module fetchUnit (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input mipsPkg::wordT target,
	input mipsPkg::wordT instRdata,
	output logic instEn,
	output mipsPkg::wordT instAddr,
	output mipsPkg::wordT pcId,
	output mipsPkg::wordT instrId,
	output logic validId
);
	import mipsPkg::*;

	wordT fetchPc;
	wordT heldInstr;
	wordT fetchedInstr;
	logic heldValid;
	logic fetchLive;

	// fetchPc is the address whose word is on instRdata in this cycle.
	assign instEn = !stall;
	assign instAddr = redirect ? target : fetchPc + 32'd4;
	assign fetchedInstr = heldValid ? heldInstr : instRdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			fetchPc <= `MIPS_RESET_PC - 32'd4;
			pcId <= '0;
			instrId <= '0;
			validId <= 1'b0;
			fetchLive <= 1'b0;
			heldValid <= 1'b0;
		end else if (!stall) begin
			fetchPc <= instAddr;
			pcId <= fetchPc;
			instrId <= fetchedInstr;
			validId <= fetchLive;
			fetchLive <= 1'b1;
			heldValid <= 1'b0;
		end else if (fetchLive) begin
			heldValid <= 1'b1;
		end
	end

	// The SRAM word only lasts one cycle, so keep it while decode is stalled.
	always_ff @(posedge clk) begin
		if (stall && !heldValid) begin
			heldInstr <= instRdata;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		instEn |-> instAddr[1:0] == 2'b00)
		else $error("fetch address 0x%08h is not word aligned", instAddr);

endmodule

//--- mipsPkg.sv
`include "mips_params.svh"

package mipsPkg;

	typedef logic [`MIPS_XLEN-1:0] wordT;
	typedef logic [$clog2(`MIPS_NREGS)-1:0] regNumT;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J = 6'h02,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI = 6'h0d,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_LBU = 6'h24,
		OP_SB = 6'h28,
		OP_SW = 6'h2b
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI,
		ALU_PASSB
	} aluOpT;

	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_LW,
		MEM_LBU,
		MEM_SW,
		MEM_SB
	} memOpT;

	typedef enum logic [1:0] {
		FWD_REGFILE,
		FWD_FROM_MEM,
		FWD_FROM_WB
	} fwdSelT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		memOpT memOp;
		logic regWrite;
		regNumT dest;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT pc;
		ctrlT ctrl;
		regNumT rs;
		regNumT rt;
		wordT rsValue;
		wordT rtValue;
		wordT imm32;
	} idExT;

	typedef struct packed {
		logic valid;
		wordT pc;
		ctrlT ctrl;
		wordT aluResult;
		logic [1:0] byteOffset;
	} exMemT;

	typedef struct packed {
		logic valid;
		wordT pc;
		logic regWrite;
		regNumT dest;
		wordT result;
	} memWbT;

	typedef struct packed {
		wordT pc;
		logic [3:0] wen;
		regNumT wnum;
		wordT wdata;
	} debugWbT;

	typedef struct packed {
		logic en;
		logic [3:0] wen;
		wordT addr;
		wordT wdata;
	} sramReqT;

	// Operand source picked by the forwarding logic.
	function automatic wordT fwdValue(input fwdSelT sel, input wordT rfValue,
			input wordT memValue, input wordT wbValue);
		case (sel)
		FWD_FROM_MEM: return memValue;
		FWD_FROM_WB: return wbValue;
		default: return rfValue;
		endcase
	endfunction

endpackage

//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Core-wide sizes and the boot address.

// First instruction fetched after reset.
`define MIPS_RESET_PC 32'h0000_0000

// Data path width in bits.
`define MIPS_XLEN 32

// Architectural register count, register zero included.
`define MIPS_NREGS 32

`endif
